/* hdl/corePkg.sv */
`default_nettype none

package corePkg;

	typedef logic [31:0] word_t;     // data, address and instruction word
	typedef logic [4:0]  regAddr_t;  // register index
	typedef logic [3:0]  aluCtrl_t;  // ALU operation code
	typedef logic [5:0]  imemAddr_t; // instruction memory word index
	typedef logic [5:0]  dmemAddr_t; // data memory word index

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;

	// major opcodes of the supported subset
	localparam logic [6:0] OP_RTYPE  = 7'b0110011; // add, sub, xor, mul
	localparam logic [6:0] OP_ITYPE  = 7'b0010011; // addi, slli
	localparam logic [6:0] OP_LOAD   = 7'b0000011; // lw
	localparam logic [6:0] OP_STORE  = 7'b0100011; // sw
	localparam logic [6:0] OP_BRANCH = 7'b1100011; // beq, bge

	// ALU codes
	localparam aluCtrl_t ALU_MUL = 4'd1;
	localparam aluCtrl_t ALU_ADD = 4'd2;
	localparam aluCtrl_t ALU_SLL = 4'd3;
	localparam aluCtrl_t ALU_XOR = 4'd4;
	localparam aluCtrl_t ALU_BEQ = 4'd5;
	localparam aluCtrl_t ALU_SUB = 4'd6;
	localparam aluCtrl_t ALU_BGE = 4'd7;

	// main control bundle, msb first as in the decode table
	typedef struct packed {
		logic       aluSrc;   // second operand is the immediate
		logic       memToReg; // writeback from data memory
		logic       regWrite;
		logic       memWrite;
		logic       branch;
		logic [1:0] aluOp;    // 00 mem, 01 branch, 10 R-type, 11 I-type
	} ctrl_t;

	// instruction memory load port
	typedef struct packed {
		logic      we;
		imemAddr_t addr;
		word_t     data;
	} progWrite_t;

	// store observed at the top level
	typedef struct packed {
		logic      valid;
		dmemAddr_t addr;
		word_t     data;
	} storeTrace_t;

endpackage

`default_nettype wire

/* hdl/programCounter.sv */
`default_nettype none

module programCounter (
	input  wire            clk,
	input  wire            rst,
	input  wire            run,
	input  wire            branchTaken,
	input  wire corePkg::word_t imm,
	output corePkg::word_t pc
);
	import corePkg::*;

	word_t nextPc;
	word_t branchTarget;

	assign branchTarget = pc + (imm << 1); // B immediate is in half words
	assign nextPc = branchTaken ? branchTarget : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (run) begin
			pc <= nextPc; // holds while run is low
		end
	end

	// branch offsets are even half words in this subset, so alignment
	// depends on every immediate the program supplies
	pcAligned: assert property (
		@(posedge clk) disable iff (rst)
		pc[1:0] == 2'b00
	) else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

/* hdl/instrDecoder.sv */
`default_nettype none

module instrDecoder (
	input  wire corePkg::word_t   instr,
	output corePkg::ctrl_t   ctrl,
	output corePkg::aluCtrl_t aluCtrl,
	output corePkg::word_t   imm
);
	import corePkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [1:0] funct7; // bit 30 and bit 25 only

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = {instr[30], instr[25]};

	// main control
	always_comb begin
		ctrl = '0; // unknown opcodes retire as no-ops
		case (opcode)
			OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = 2'b10;
			end
			OP_ITYPE: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = 2'b11;
			end
			OP_LOAD: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = 2'b00; // address add
			end
			OP_STORE: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluOp    = 2'b00;
			end
			OP_BRANCH: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp  = 2'b01; // compare rs1 with rs2
			end
			default: ctrl = '0;
		endcase
	end

	// ALU control
	always_comb begin
		aluCtrl = ALU_ADD;
		case (ctrl.aluOp)
			2'b01: begin
				case (funct3)
					3'd0:    aluCtrl = ALU_BEQ;
					3'd5:    aluCtrl = ALU_BGE;
					default: aluCtrl = ALU_ADD; // never taken
				endcase
			end
			2'b10: begin
				case ({funct7, funct3})
					5'b00_000: aluCtrl = ALU_ADD;
					5'b10_000: aluCtrl = ALU_SUB;
					5'b00_100: aluCtrl = ALU_XOR;
					5'b01_000: aluCtrl = ALU_MUL; // M extension, funct7 = 1
					default:   aluCtrl = ALU_ADD;
				endcase
			end
			2'b11: begin
				aluCtrl = (funct3 == 3'd1) ? ALU_SLL : ALU_ADD;
			end
			default: aluCtrl = ALU_ADD; // lw, sw
		endcase
	end

	// immediate generation, sign extended
	always_comb begin
		case (opcode)
			OP_ITYPE, OP_LOAD: imm = {{20{instr[31]}}, instr[31:20]};
			OP_STORE:          imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			// offset bits 12:1, doubled in the PC
			OP_BRANCH: imm = {{20{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8]};
			default:   imm = '0;
		endcase
	end

	// the control table must never ask for both writes in one instruction
	always_comb begin
		assert (!(ctrl.regWrite && ctrl.memWrite))
			else $error("regWrite and memWrite both set, opcode %b", opcode);
	end

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`default_nettype none

module regFile (
	input  wire            clk,
	input  wire            rst,
	input  wire            we,
	input  wire corePkg::regAddr_t rs1,
	input  wire corePkg::regAddr_t rs2,
	input  wire corePkg::regAddr_t rd,
	input  wire corePkg::word_t    wdata,
	output corePkg::word_t    rs1Data,
	output corePkg::word_t    rs2Data
);
	import corePkg::*;

	word_t regs [32];

	// asynchronous read
	assign rs1Data = regs[rs1];
	assign rs2Data = regs[rs2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != 5'd0) begin
			regs[rd] <= wdata; // x0 stays at its reset value
		end
	end

	// x0 reads as zero only because reset cleared it and writes skip it
	x0Zero: assert property (
		@(posedge clk) disable iff (rst)
		rs1 == 5'd0 |-> rs1Data == '0
	) else $error("x0 read back %h", rs1Data);

endmodule

`default_nettype wire

/* hdl/aluUnit.sv */
`default_nettype none

module aluUnit (
	input  wire corePkg::word_t    rs1Data,
	input  wire corePkg::word_t    rs2Data,
	input  wire corePkg::word_t    imm,
	input  wire            aluSrc,
	input  wire corePkg::aluCtrl_t aluCtrl,
	output corePkg::word_t    result,
	output logic           takeBranch
);
	import corePkg::*;

	word_t operandB;

	assign operandB = aluSrc ? imm : rs2Data; // operand select

	always_comb begin
		result     = '0;
		takeBranch = 1'b0;
		case (aluCtrl)
			ALU_ADD: result = rs1Data + operandB;
			ALU_SUB: result = rs1Data - operandB;
			ALU_XOR: result = rs1Data ^ operandB;
			ALU_MUL: result = rs1Data * operandB;    // low 32 bits
			ALU_SLL: result = rs1Data << operandB[4:0]; // shamt field
			ALU_BEQ: begin
				takeBranch = (rs1Data == operandB);
			end
			ALU_BGE: begin
				// signed compare
				takeBranch = ($signed(rs1Data) >= $signed(operandB));
			end
			default: begin
				result     = '0;
				takeBranch = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/instrMem.sv */
`default_nettype none

module instrMem (
	input  wire              clk,
	input  wire corePkg::progWrite_t prog,
	input  wire corePkg::word_t      pc,
	output corePkg::word_t      instr
);
	import corePkg::*;

	word_t mem [IMEM_WORDS];

	assign instr = mem[pc[7:2]]; // word index

	// load port, used by the testbench while the core is stopped
	always_ff @(posedge clk) begin
		if (prog.we) begin
			mem[prog.addr] <= prog.data;
		end
	end

endmodule

`default_nettype wire

/* hdl/dataMem.sv */
`default_nettype none

module dataMem (
	input  wire         clk,
	input  wire         rst,
	input  wire         we,
	input  wire corePkg::word_t addr,
	input  wire corePkg::word_t wdata,
	output corePkg::word_t rdata
);
	import corePkg::*;

	word_t     mem [DMEM_WORDS];
	dmemAddr_t index;

	assign index = addr[7:2];
	assign rdata = mem[index]; // combinational read

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[index] <= wdata;
		end
	end

	// only word accesses exist, the address comes from rs1 plus the S offset
	wordWrite: assert property (
		@(posedge clk) disable iff (rst)
		we |-> addr[1:0] == 2'b00
	) else $error("unaligned store to %h", addr);

endmodule

`default_nettype wire

/* hdl/riscCore.sv */
`default_nettype none

module riscCore (
	input  wire                clk,
	input  wire                rst,
	input  wire                run,
	input  wire corePkg::progWrite_t   prog,
	output corePkg::word_t        pc,
	output corePkg::storeTrace_t  store
);
	import corePkg::*;

	word_t    instr;
	ctrl_t    ctrl;
	aluCtrl_t aluCtrl;
	word_t    imm;
	word_t    rs1Data;
	word_t    rs2Data;
	word_t    result;
	word_t    loadData;
	word_t    wbData;
	logic     takeBranch;
	logic     branchTaken;
	logic     regWe;
	logic     memWe;

	assign regWe       = ctrl.regWrite & run; // no state change while stopped
	assign memWe       = ctrl.memWrite & run;
	assign branchTaken = ctrl.branch & takeBranch;
	assign wbData      = ctrl.memToReg ? loadData : result;
	assign store       = '{valid: memWe, addr: result[7:2], data: rs2Data};

	programCounter u_pc (
		.clk(clk), .rst(rst), .run(run),
		.branchTaken(branchTaken), .imm(imm), .pc(pc)
	);

	instrMem u_imem (.clk(clk), .prog(prog), .pc(pc), .instr(instr));

	instrDecoder u_dec (.instr(instr), .ctrl(ctrl), .aluCtrl(aluCtrl), .imm(imm));

	regFile u_regs (
		.clk(clk), .rst(rst), .we(regWe),
		.rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]),
		.wdata(wbData), .rs1Data(rs1Data), .rs2Data(rs2Data)
	);

	aluUnit u_alu (
		.rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm), .aluSrc(ctrl.aluSrc),
		.aluCtrl(aluCtrl), .result(result), .takeBranch(takeBranch)
	);

	dataMem u_dmem (
		.clk(clk), .rst(rst), .we(memWe),
		.addr(result), .wdata(rs2Data), .rdata(loadData)
	);

endmodule

`default_nettype wire

/* verif/coreTb.sv */
`default_nettype none

module coreTb;
	timeunit 1ns;
	timeprecision 1ps;
	import corePkg::*;

	localparam int PERIOD = 40;
	localparam int TEST_CYCLES = 80; // worst case load, reset and run of one test
	localparam int WATCHDOG_NS = (5 * TEST_CYCLES + 11) * PERIOD + 2000;

	logic        clk;
	logic        rst;
	logic        run;
	progWrite_t  prog;
	word_t       pc;
	storeTrace_t store;

	word_t       progBuf [$];  // program being assembled
	word_t       pcLog [$];    // pc seen in each run cycle
	storeTrace_t storeLog [$]; // valid stores in order

	riscCore u_dut (.clk(clk), .rst(rst), .run(run), .prog(prog), .pc(pc), .store(store));

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		stopWithError("watchdog expired before all tests finished");
	end

	task automatic stopWithError(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			stopWithError($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
		end
	endtask

	function automatic word_t sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic word_t rType(input logic [6:0] f7, input regAddr_t rs2,
			input regAddr_t rs1, input logic [2:0] f3, input regAddr_t rd);
		return {f7, rs2, rs1, f3, rd, OP_RTYPE};
	endfunction

	function automatic word_t iType(input logic [6:0] op, input logic [11:0] imm,
			input regAddr_t rs1, input logic [2:0] f3, input regAddr_t rd);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t addi(input regAddr_t rd, input regAddr_t rs1, input logic [11:0] imm);
		return iType(OP_ITYPE, imm, rs1, 3'd0, rd);
	endfunction

	function automatic word_t sType(input logic [11:0] imm, input regAddr_t rs2, input regAddr_t rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	// offset in bytes, bit 0 dropped by the encoding
	function automatic word_t bType(input logic [12:0] off, input regAddr_t rs2,
			input regAddr_t rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
	endfunction

	function automatic word_t selfLoop();
		return bType(13'd0, 5'd0, 5'd0, 3'd0); // beq x0,x0,0
	endfunction

	task automatic applyReset(input int cycles);
		@(negedge clk);
		rst = 1'b1;
		repeat (cycles) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic loadProgram();
		run = 1'b0;
		foreach (progBuf[i]) begin
			@(negedge clk);
			prog.we   = 1'b1;
			prog.addr = imemAddr_t'(i);
			prog.data = progBuf[i];
		end
		@(negedge clk);
		prog.we = 1'b0;
		applyReset(10);
	endtask

	// one posedge per iteration, sampled a quarter period after the falling edge
	task automatic runProgram(input int cycles);
		pcLog.delete();
		storeLog.delete();
		@(negedge clk);
		run = 1'b1;
		for (int c = 0; c < cycles; c++) begin
			#(PERIOD / 4);
			pcLog.push_back(pc);
			if (store.valid) storeLog.push_back(store);
			@(negedge clk);
		end
		run = 1'b0;
	endtask

	task automatic checkStore(input int idx, input int wordIdx, input word_t data);
		check("store.addr", 32'(wordIdx), {26'd0, storeLog[idx].addr});
		check("store.data", data, storeLog[idx].data);
	endtask

	// straight code ending in the self loop at word loopWord
	task automatic checkStraightPc(input int loopWord);
		foreach (pcLog[i]) begin
			check("pc", 32'(4 * ((i < loopWord) ? i : loopWord)), pcLog[i]);
		end
	endtask

	task automatic arithTest();
		logic [11:0] a;
		logic [11:0] b;
		word_t       x;
		word_t       y;
		word_t       expected [4];
		a = 12'($urandom);
		b = 12'($urandom);
		x = sext12(a);
		y = sext12(b);
		expected[0] = x + y;
		expected[1] = x - y;
		expected[2] = x ^ y;
		expected[3] = x * y; // low 32 bits
		progBuf.delete();
		progBuf.push_back(addi(5'd1, 5'd0, a));
		progBuf.push_back(addi(5'd2, 5'd0, b));
		progBuf.push_back(rType(7'h00, 5'd2, 5'd1, 3'd0, 5'd3)); // add
		progBuf.push_back(rType(7'h20, 5'd2, 5'd1, 3'd0, 5'd4)); // sub
		progBuf.push_back(rType(7'h00, 5'd2, 5'd1, 3'd4, 5'd5)); // xor
		progBuf.push_back(rType(7'h01, 5'd2, 5'd1, 3'd0, 5'd6)); // mul
		for (int i = 0; i < 4; i++) begin
			progBuf.push_back(sType(12'(4 * i), regAddr_t'(3 + i), 5'd0));
		end
		progBuf.push_back(selfLoop());
		loadProgram();
		runProgram(12);
		check("store count", 32'd4, 32'(storeLog.size()));
		for (int i = 0; i < 4; i++) checkStore(i, i, expected[i]);
		checkStraightPc(10);
	endtask

	task automatic shiftTest();
		logic [11:0] v;
		logic [4:0]  s;
		v = 12'($urandom);
		s = 5'($urandom);
		progBuf.delete();
		progBuf.push_back(addi(5'd1, 5'd0, v));
		progBuf.push_back(iType(OP_ITYPE, {7'd0, s}, 5'd1, 3'd1, 5'd2)); // slli
		progBuf.push_back(addi(5'd0, 5'd0, v | 12'd1)); // write to x0 is dropped
		progBuf.push_back(sType(12'd16, 5'd2, 5'd0));
		progBuf.push_back(sType(12'd20, 5'd0, 5'd0));
		progBuf.push_back(selfLoop());
		loadProgram();
		runProgram(7);
		check("store count", 32'd2, 32'(storeLog.size()));
		checkStore(0, 4, sext12(v) << s);
		checkStore(1, 5, 32'd0);
		checkStraightPc(5);
	endtask

	task automatic loadStoreTest();
		logic [11:0] v;
		v = 12'($urandom);
		progBuf.delete();
		progBuf.push_back(addi(5'd1, 5'd0, v));
		progBuf.push_back(addi(5'd7, 5'd0, 12'd32)); // base address
		progBuf.push_back(sType(12'd4, 5'd1, 5'd7));
		progBuf.push_back(iType(OP_LOAD, 12'd4, 5'd7, 3'd2, 5'd2)); // lw x2,4(x7)
		progBuf.push_back(sType(12'd8, 5'd2, 5'd7));
		progBuf.push_back(selfLoop());
		loadProgram();
		runProgram(7);
		check("store count", 32'd2, 32'(storeLog.size()));
		checkStore(0, 9, sext12(v));
		checkStore(1, 10, sext12(v));
		checkStraightPc(5);
	endtask

	task automatic branchTest();
		logic [11:0] a;
		logic [11:0] b;
		word_t       x;
		word_t       y;
		logic [2:0]  f3 [5];
		regAddr_t    rsA [5];
		regAddr_t    rsB [5];
		logic        taken [5];
		word_t       at;
		int          idx;
		a = 12'($urandom);
		do b = 12'($urandom); while (b == a);
		x = sext12(a);
		y = sext12(b);
		f3  = '{3'd0, 3'd0, 3'd5, 3'd5, 3'd5}; // beq, beq, bge, bge, bge
		rsA = '{5'd1, 5'd1, 5'd1, 5'd2, 5'd1};
		rsB = '{5'd2, 5'd3, 5'd2, 5'd1, 5'd3}; // x3 holds the same value as x1
		taken[0] = 1'b0;
		taken[1] = 1'b1;
		taken[2] = ($signed(x) >= $signed(y));
		taken[3] = ($signed(y) >= $signed(x));
		taken[4] = 1'b1;
		progBuf.delete();
		progBuf.push_back(addi(5'd1, 5'd0, a));
		progBuf.push_back(addi(5'd2, 5'd0, b));
		progBuf.push_back(addi(5'd3, 5'd0, a));
		for (int j = 0; j < 5; j++) begin
			progBuf.push_back(bType(13'd12, rsB[j], rsA[j], f3[j]));
			progBuf.push_back(addi(5'd9, 5'd0, 12'(32'h200 + j))); // fall-through marker
			progBuf.push_back(bType(13'd8, 5'd0, 5'd0, 3'd0));
			progBuf.push_back(addi(5'd9, 5'd0, 12'(32'h100 + j))); // taken marker
			progBuf.push_back(sType(12'(4 * j), 5'd9, 5'd0));
		end
		progBuf.push_back(selfLoop());
		loadProgram();
		runProgram(26);
		check("store count", 32'd5, 32'(storeLog.size()));
		for (int j = 0; j < 5; j++) begin
			checkStore(j, j, taken[j] ? 32'(32'h100 + j) : 32'(32'h200 + j));
			at  = 32'(12 + 20 * j);
			idx = -1;
			foreach (pcLog[i]) begin
				if (idx < 0 && pcLog[i] == at) idx = i;
			end
			if (idx < 0 || idx + 1 >= pcLog.size()) begin
				stopWithError($sformatf("branch at %h was never executed", at));
			end
			check("pc", taken[j] ? at + 32'd12 : at + 32'd4, pcLog[idx + 1]);
		end
	endtask

	task automatic resetRunTest();
		progBuf.delete();
		progBuf.push_back(sType(12'd0, 5'd5, 5'd0)); // x5 never written
		progBuf.push_back(iType(OP_LOAD, 12'd36, 5'd0, 3'd2, 5'd6)); // word set earlier
		progBuf.push_back(addi(5'd1, 5'd1, 12'd1));
		progBuf.push_back(addi(5'd1, 5'd1, 12'd1));
		progBuf.push_back(sType(12'd4, 5'd6, 5'd0));
		progBuf.push_back(sType(12'd8, 5'd1, 5'd0));
		progBuf.push_back(selfLoop());
		loadProgram();
		repeat (5) begin
			#(PERIOD / 4);
			check("pc", 32'd0, pc);
			check("store.valid", 32'd0, {31'd0, store.valid}); // first word is a store
			@(negedge clk);
		end
		runProgram(7);
		check("store count", 32'd3, 32'(storeLog.size()));
		checkStore(0, 0, 32'd0);
		checkStore(1, 1, 32'd0); // data memory cleared by reset
		checkStore(2, 2, 32'd2);
		checkStraightPc(6);
	endtask

	initial begin
		rst  = 1'b1;
		run  = 1'b0;
		prog = '0;
		void'($urandom(32'h9970_339a));
		applyReset(10);
		arithTest();
		shiftTest();
		loadStoreTest();
		branchTest();
		resetRunTest();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hdl/corePkg.sv
hdl/programCounter.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/instrMem.sv
hdl/dataMem.sv
hdl/riscCore.sv
verif/coreTb.sv

/* run.sh */
#!/bin/sh
# build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module coreTb -Mdir obj_dir -o coreSim -f vlog.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/coreSim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
